/* design/hub75_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// panel geometry, bcm timing and register map
// shared enums and packed structs
// ~~~~~~~~~~~~~~~~~~~~
package hub75_pkg;

    localparam int PANEL_WIDTH   = 16;
    localparam int PANEL_HEIGHT  = 8;
    localparam int HALF_HEIGHT   = PANEL_HEIGHT / 2;   // rows driven at once
    localparam int BCM_BITS      = 4;                  // brightness bits per colour
    localparam int BASE_ON_TICKS = 4;                  // plane 0 on time
    localparam int ON_CNT_BITS   = $clog2(BASE_ON_TICKS << (BCM_BITS - 1)) + 1;
    localparam int FB_DEPTH      = PANEL_WIDTH * PANEL_HEIGHT;
    localparam int FB_ADDR_BITS  = $clog2(FB_DEPTH);
    localparam logic [9:0] CTRL_ADDR = 10'h200;

    typedef struct packed {
        logic [BCM_BITS-1:0] red;
        logic [BCM_BITS-1:0] green;
        logic [BCM_BITS-1:0] blue;
    } pixel_t;

    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;        // row * PANEL_WIDTH + col
    typedef logic [$clog2(HALF_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(PANEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(BCM_BITS)-1:0] plane_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        logic [2:0]          rgb_enable;
        logic [BCM_BITS-1:0] plane_enable;
    } ctrl_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [9:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     valid;
        logic     we;
        fb_addr_t addr;
        pixel_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic   rvalid;
        pixel_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic   valid;
        row_t   row;
        col_t   col;
        plane_t plane;
    } col_req_t;

    typedef struct packed {
        logic valid;
        rgb_t top;
        rgb_t bottom;
    } col_data_t;

    // output_enable active high, inverted on the board
    typedef struct packed {
        rgb_t       rgb_top;
        rgb_t       rgb_bottom;
        logic       clk_pixel;
        logic       latch;
        logic       output_enable;
        logic [3:0] row_addr;       // A..D lines
    } hub75_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SHIFT,
        S_WAIT_COL,
        S_LATCH,
        S_DISPLAY
    } scan_state_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ_TOP,
        F_READ_BOTTOM,
        F_SLICE
    } fetch_state_t;

endpackage

/* design/framebuffer_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// single port pixel memory
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module framebuffer_ram (
    input  logic                clk_root,
    input  hub75_pkg::mem_req_t ram_req,
    output hub75_pkg::pixel_t   ram_rdata
);
    import hub75_pkg::*;

    pixel_t mem [FB_DEPTH];

    always_ff @(posedge clk_root) begin
        if (ram_req.valid) begin
            if (ram_req.we) begin
                mem[ram_req.addr] <= ram_req.wdata;
            end else begin
                ram_rdata <= mem[ram_req.addr];   // one cycle read latency
            end
        end
    end

endmodule

/* design/fb_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// fixed priority framebuffer arbiter
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fb_arbiter (
    input  logic                clk_root,
    input  logic                reset,
    input  hub75_pkg::mem_req_t fetch_mem_req,
    output hub75_pkg::mem_rsp_t fetch_mem_rsp,
    input  hub75_pkg::mem_req_t regs_mem_req,
    output logic                regs_grant,
    output hub75_pkg::mem_rsp_t regs_mem_rsp,
    output hub75_pkg::mem_req_t ram_req,
    input  hub75_pkg::pixel_t   ram_rdata
);
    import hub75_pkg::*;

    logic fetch_rd_q;   // which port owns the read in flight
    logic regs_rd_q;

    // register side only gets the ram when the fetch unit is quiet
    assign regs_grant = regs_mem_req.valid && !fetch_mem_req.valid;

    always_comb begin
        if (fetch_mem_req.valid) begin
            ram_req = fetch_mem_req;
        end else begin
            ram_req = regs_mem_req;
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            fetch_rd_q <= 1'b0;
            regs_rd_q  <= 1'b0;
        end else begin
            fetch_rd_q <= fetch_mem_req.valid && !fetch_mem_req.we;
            regs_rd_q  <= regs_grant && !regs_mem_req.we;
        end
    end

    always_comb begin
        fetch_mem_rsp.rvalid = fetch_rd_q;
        fetch_mem_rsp.rdata  = ram_rdata;
        regs_mem_rsp.rvalid  = regs_rd_q;
        regs_mem_rsp.rdata   = ram_rdata;
    end

endmodule

/* design/apb_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// apb slave, control register and
// pixel access to the framebuffer
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module apb_regs (
    input  logic                clk_root,
    input  logic                reset,
    input  hub75_pkg::apb_req_t apb_req,
    output hub75_pkg::apb_rsp_t apb_rsp,
    output hub75_pkg::mem_req_t regs_mem_req,
    input  logic                regs_grant,
    input  hub75_pkg::mem_rsp_t regs_mem_rsp,
    output hub75_pkg::ctrl_t    ctrl
);
    import hub75_pkg::*;

    logic access;
    logic is_pixel;
    logic is_ctrl;
    logic is_err;
    logic rd_pending;   // pixel read granted, data due next cycle

    assign access   = apb_req.psel && apb_req.penable;
    assign is_pixel = apb_req.paddr < 10'(FB_DEPTH);
    assign is_ctrl  = apb_req.paddr == CTRL_ADDR;
    assign is_err   = !is_pixel && !is_ctrl;

    // request held through the access phase until the arbiter grants it
    always_comb begin
        regs_mem_req.valid = access && is_pixel && !rd_pending;
        regs_mem_req.we    = apb_req.pwrite;
        regs_mem_req.addr  = fb_addr_t'(apb_req.paddr);
        regs_mem_req.wdata = pixel_t'(apb_req.pwdata[$bits(pixel_t)-1:0]);
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= regs_grant && !regs_mem_req.we;
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            ctrl <= '1;   // all colours and planes on
        end else if (access && is_ctrl && apb_req.pwrite) begin
            ctrl <= ctrl_t'(apb_req.pwdata[$bits(ctrl_t)-1:0]);
        end
    end

    always_comb begin
        apb_rsp.pslverr = access && is_err;
        apb_rsp.pready  = 1'b0;
        apb_rsp.prdata  = '0;
        if (access) begin
            if (!is_pixel) begin
                apb_rsp.pready = 1'b1;   // ctrl and decode error finish at once
            end else if (apb_req.pwrite) begin
                apb_rsp.pready = regs_grant;
            end else begin
                apb_rsp.pready = regs_mem_rsp.rvalid;
            end

            if (is_ctrl && !apb_req.pwrite) begin
                apb_rsp.prdata = 32'(ctrl);
            end else if (is_pixel && regs_mem_rsp.rvalid) begin
                apb_rsp.prdata = 32'(regs_mem_rsp.rdata);   // zero-extended
            end
        end
    end

endmodule

/* design/scan_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// row and bit plane scan FSM
// drives pixel clock, latch and output enable
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module scan_sequencer (
    input  logic                 clk_root,
    input  logic                 reset,
    output hub75_pkg::col_req_t  col_req,
    input  hub75_pkg::col_data_t col_data,
    output hub75_pkg::hub75_t    panel
);
    import hub75_pkg::*;

    scan_state_t            state;
    row_t                   row;
    plane_t                 plane;
    col_t                   col;
    logic [ON_CNT_BITS-1:0] on_cnt;
    logic [ON_CNT_BITS-1:0] on_ticks;
    logic                   clk_pixel;
    logic                   latch;
    logic                   output_enable;
    logic [3:0]             row_addr;
    rgb_t                   rgb_top;
    rgb_t                   rgb_bottom;

    // bcm weight doubles per plane
    assign on_ticks = ON_CNT_BITS'(BASE_ON_TICKS) << plane;

    always_comb begin
        col_req.valid = state == S_SHIFT;   // single cycle pulse
        col_req.row   = row;
        col_req.col   = col;
        col_req.plane = plane;
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state         <= S_IDLE;
            row           <= '0;
            plane         <= '0;
            col           <= '0;
            on_cnt        <= '0;
            clk_pixel     <= 1'b0;
            latch         <= 1'b0;
            output_enable <= 1'b0;
            row_addr      <= '0;
        end else begin
            clk_pixel <= 1'b0;
            latch     <= 1'b0;
            case (state)
                S_IDLE: begin
                    state <= S_SHIFT;
                end
                S_SHIFT: begin
                    state <= S_WAIT_COL;
                end
                S_WAIT_COL: begin
                    if (col_data.valid) begin
                        clk_pixel <= 1'b1;   // shift on the next cycle
                        col       <= col + 1'b1;
                        if (col == col_t'(PANEL_WIDTH - 1)) begin
                            state <= S_LATCH;
                        end else begin
                            state <= S_SHIFT;
                        end
                    end
                end
                S_LATCH: begin
                    latch    <= 1'b1;
                    row_addr <= {2'b00, row};   // row changes with the latch
                    on_cnt   <= on_ticks;
                    state    <= S_DISPLAY;
                end
                S_DISPLAY: begin
                    if (on_cnt != '0) begin
                        output_enable <= 1'b1;
                        on_cnt        <= on_cnt - 1'b1;
                    end else begin
                        output_enable <= 1'b0;
                        plane         <= plane + 1'b1;
                        if (plane == plane_t'(BCM_BITS - 1)) begin
                            row <= row + 1'b1;   // wraps after last row
                        end
                        state <= S_SHIFT;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // colour data held between pixel clocks
    always_ff @(posedge clk_root) begin
        if (state == S_WAIT_COL && col_data.valid) begin
            rgb_top    <= col_data.top;
            rgb_bottom <= col_data.bottom;
        end
    end

    always_comb begin
        panel.rgb_top       = rgb_top;
        panel.rgb_bottom    = rgb_bottom;
        panel.clk_pixel     = clk_pixel;
        panel.latch         = latch;
        panel.output_enable = output_enable;
        panel.row_addr      = row_addr;
    end

endmodule

/* design/column_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// column fetch, top and bottom pixel
// sliced to the current bit plane
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module column_fetch (
    input  logic                 clk_root,
    input  logic                 reset,
    input  hub75_pkg::col_req_t  col_req,
    input  hub75_pkg::ctrl_t     ctrl,
    output hub75_pkg::mem_req_t  fetch_mem_req,
    input  hub75_pkg::mem_rsp_t  fetch_mem_rsp,
    output hub75_pkg::col_data_t col_data
);
    import hub75_pkg::*;

    fetch_state_t state;
    row_t         row_q;
    col_t         col_q;
    plane_t       plane_q;
    rgb_t         top_q;
    fb_addr_t     top_addr;
    fb_addr_t     bottom_addr;

    // bit p of each nibble, masked by colour and plane enables
    function automatic rgb_t slice_plane(pixel_t pix, plane_t p, ctrl_t c);
        rgb_t bits;
        bits = {pix.red[p], pix.green[p], pix.blue[p]};
        return bits & c.rgb_enable & {3{c.plane_enable[p]}};
    endfunction

    assign top_addr    = fb_addr_t'(int'(row_q) * PANEL_WIDTH + int'(col_q));
    assign bottom_addr = fb_addr_t'((int'(row_q) + HALF_HEIGHT) * PANEL_WIDTH + int'(col_q));

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state <= F_IDLE;
        end else begin
            case (state)
                F_IDLE: begin
                    if (col_req.valid) begin
                        state <= F_READ_TOP;
                    end
                end
                F_READ_TOP:    state <= F_READ_BOTTOM;
                F_READ_BOTTOM: state <= F_SLICE;
                default:       state <= F_IDLE;   // F_SLICE
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == F_IDLE && col_req.valid) begin
            row_q   <= col_req.row;
            col_q   <= col_req.col;
            plane_q <= col_req.plane;
        end
        if (state == F_READ_BOTTOM && fetch_mem_rsp.rvalid) begin
            top_q <= slice_plane(fetch_mem_rsp.rdata, plane_q, ctrl);   // top pixel returns
        end
    end

    always_comb begin
        fetch_mem_req.valid = state == F_READ_TOP || state == F_READ_BOTTOM;
        fetch_mem_req.we    = 1'b0;
        fetch_mem_req.addr  = (state == F_READ_TOP) ? top_addr : bottom_addr;
        fetch_mem_req.wdata = '0;
    end

    // bottom pixel lands in the slice cycle, three cycles after the request
    always_comb begin
        col_data.valid  = state == F_SLICE && fetch_mem_rsp.rvalid;
        col_data.top    = top_q;
        col_data.bottom = slice_plane(fetch_mem_rsp.rdata, plane_q, ctrl);
    end

endmodule

/* design/hub75_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// hub75 panel driver top level
// apb registers, shared framebuffer, scan and fetch
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hub75_top (
    input  logic                clk_root,
    input  logic                reset,
    input  hub75_pkg::apb_req_t apb_req,
    output hub75_pkg::apb_rsp_t apb_rsp,
    output hub75_pkg::hub75_t   panel
);
    import hub75_pkg::*;

    mem_req_t  regs_mem_req;
    mem_rsp_t  regs_mem_rsp;
    logic      regs_grant;
    mem_req_t  fetch_mem_req;
    mem_rsp_t  fetch_mem_rsp;
    mem_req_t  ram_req;
    pixel_t    ram_rdata;
    ctrl_t     ctrl;
    col_req_t  col_req;
    col_data_t col_data;

    apb_regs u_regs (
        .clk_root     (clk_root),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .regs_mem_req (regs_mem_req),
        .regs_grant   (regs_grant),
        .regs_mem_rsp (regs_mem_rsp),
        .ctrl         (ctrl)
    );

    // fetch side always has priority
    fb_arbiter u_arb (
        .clk_root      (clk_root),
        .reset         (reset),
        .fetch_mem_req (fetch_mem_req),
        .fetch_mem_rsp (fetch_mem_rsp),
        .regs_mem_req  (regs_mem_req),
        .regs_grant    (regs_grant),
        .regs_mem_rsp  (regs_mem_rsp),
        .ram_req       (ram_req),
        .ram_rdata     (ram_rdata)
    );

    framebuffer_ram u_fb (
        .clk_root  (clk_root),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    scan_sequencer u_scan (
        .clk_root (clk_root),
        .reset    (reset),
        .col_req  (col_req),
        .col_data (col_data),
        .panel    (panel)
    );

    column_fetch u_fetch (
        .clk_root      (clk_root),
        .reset         (reset),
        .col_req       (col_req),
        .ctrl          (ctrl),
        .fetch_mem_req (fetch_mem_req),
        .fetch_mem_rsp (fetch_mem_rsp),
        .col_data      (col_data)
    );

endmodule

/* tests/hub75_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// hub75 driver testbench, apb tasks, framebuffer
// shadow model and scan checks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hub75_tb;
    import hub75_pkg::*;

    localparam int MAX_CYCLES = 6000;   // writes, readbacks and two frames

    logic        clk_root;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    hub75_t      panel;

    logic [11:0] shadow [FB_DEPTH];
    logic [6:0]  ctrl_shadow;
    logic [6:0]  ctrl_active;        // mask of the shift phase in progress
    logic        regs_changed;       // write landed since the monitor last looked
    logic        rgb_ok;
    logic        fb_loaded;
    logic        oe_q;
    logic        latch_q;
    integer      seed;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          stall_cycles;
    int          cycle_cnt;
    int          latch_cnt;
    int          pix_cnt;
    int          oe_cnt;
    int          disp_row;
    int          disp_plane;

    hub75_top dut (
        .clk_root (clk_root),
        .reset    (reset),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .panel    (panel)
    );

    initial begin
        clk_root = 1'b0;
        forever #2 clk_root = ~clk_root;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_root);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // bit p of each nibble, red nibble on top
    function automatic logic [2:0] expected_bits(logic [11:0] pix, int p, logic [6:0] c);
        logic [2:0] bits;
        bits = {pix[8 + p], pix[4 + p], pix[p]};
        if (!c[p]) begin
            bits = 3'b000;   // plane switched off
        end
        return bits & c[6:4];
    endfunction

    task automatic apb_transfer(input logic write, input logic [9:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        @(negedge clk_root);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_root);
        apb_req.penable = 1'b1;
        @(posedge clk_root);
        while (!apb_rsp.pready) begin
            if (write) begin
                stall_cycles++;
            end
            @(posedge clk_root);
        end
        rdata  = apb_rsp.prdata;   // transfer completes on this edge
        slverr = apb_rsp.pslverr;
    endtask

    task automatic bus_idle();
        @(negedge clk_root);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_pixel(input int addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b1, 10'(addr), data, rdata, slverr);
        shadow[addr] = data[11:0];
        regs_changed = 1'b1;
        assert (!slverr) else begin
            value_errors++;
            $display("FAIL apb_rsp.pslverr write 0x%h: got 0x%h expected 0x0", addr, slverr);
        end
    endtask

    task automatic check_pixel(input int addr);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b0, 10'(addr), 32'h0, rdata, slverr);
        assert (rdata == {20'h0, shadow[addr]} && !slverr) else begin
            value_errors++;
            $display("FAIL apb_rsp.prdata read 0x%h: got 0x%h/0x%h expected 0x%h/0x0",
                     addr, rdata, slverr, {20'h0, shadow[addr]});
        end
    endtask

    task automatic write_ctrl(input logic [31:0] data);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b1, CTRL_ADDR, data, rdata, slverr);
        ctrl_shadow  = data[6:0];
        regs_changed = 1'b1;
        assert (!slverr) else begin
            value_errors++;
            $display("FAIL apb_rsp.pslverr ctrl write: got 0x%h expected 0x0", slverr);
        end
    endtask

    task automatic check_ctrl();
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(1'b0, CTRL_ADDR, 32'h0, rdata, slverr);
        assert (rdata == {25'h0, ctrl_shadow} && !slverr) else begin
            value_errors++;
            $display("FAIL apb_rsp.prdata ctrl: got 0x%h/0x%h expected 0x%h/0x0",
                     rdata, slverr, {25'h0, ctrl_shadow});
        end
    endtask

    // unmapped word, must error out and return zero
    task automatic check_decode_error(input logic write);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(write, 10'h300, 32'hdead_beef, rdata, slverr);
        assert (slverr && rdata == 32'h0) else begin
            value_errors++;
            $display("FAIL apb_rsp 0x300: got prdata 0x%h pslverr 0x%h expected 0x0/0x1",
                     rdata, slverr);
        end
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_cnt + n;
        wait (latch_cnt >= target);
    endtask

    always @(negedge clk_root) begin : scan_monitor
        int         shift_row;
        int         shift_plane;
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        if (reset) begin
            latch_cnt   = 0;
            pix_cnt     = 0;
            oe_cnt      = 0;
            disp_row    = 0;
            disp_plane  = 0;
            oe_q        = 1'b0;
            latch_q     = 1'b0;
            rgb_ok      = 1'b1;
            ctrl_active = 7'h7f;
        end else begin
            shift_row   = (latch_cnt / 4) % 4;
            shift_plane = latch_cnt % 4;
            if (regs_changed) begin
                rgb_ok       = 1'b0;   // phase in flight saw the old state
                regs_changed = 1'b0;
            end
            if (oe_q && !panel.output_enable) begin
                assert (oe_cnt == (BASE_ON_TICKS << disp_plane)) else begin
                    value_errors++;
                    $display("FAIL output_enable cycles plane %0d: got 0x%h expected 0x%h",
                             disp_plane, oe_cnt, BASE_ON_TICKS << disp_plane);
                end
                ctrl_active = ctrl_shadow;   // next shift starts clean
                rgb_ok      = 1'b1;
            end
            if (panel.output_enable) begin
                oe_cnt++;
            end
            if (panel.clk_pixel && rgb_ok && fb_loaded) begin
                exp_top    = expected_bits(shadow[shift_row * PANEL_WIDTH + pix_cnt],
                                           shift_plane, ctrl_active);
                exp_bottom = expected_bits(
                    shadow[(shift_row + HALF_HEIGHT) * PANEL_WIDTH + pix_cnt],
                    shift_plane, ctrl_active);
                assert (panel.rgb_top == exp_top && panel.rgb_bottom == exp_bottom) else begin
                    value_errors++;
                    $display("FAIL panel.rgb r%0d c%0d p%0d: got 0x%h/0x%h expected 0x%h/0x%h",
                             shift_row, pix_cnt, shift_plane, panel.rgb_top,
                             panel.rgb_bottom, exp_top, exp_bottom);
                end
                assert (((panel.rgb_top | panel.rgb_bottom) & ~ctrl_active[6:4]) == 3'b000)
                else begin
                    value_errors++;
                    $display("FAIL panel.rgb disabled colour: got 0x%h/0x%h mask 0x%h",
                             panel.rgb_top, panel.rgb_bottom, ctrl_active[6:4]);
                end
                assert (ctrl_active[shift_plane] || (panel.rgb_top | panel.rgb_bottom) == 3'b000)
                else begin
                    value_errors++;
                    $display("FAIL panel.rgb disabled plane %0d: got 0x%h/0x%h expected 0x0",
                             shift_plane, panel.rgb_top, panel.rgb_bottom);
                end
            end
            if (panel.clk_pixel) begin
                pix_cnt++;
            end
            if (latch_q) begin
                assert (panel.row_addr == 4'(disp_row)) else begin
                    value_errors++;
                    $display("FAIL panel.row_addr: got 0x%h expected 0x%h",
                             panel.row_addr, disp_row);
                end
            end
            if (panel.latch) begin
                assert (pix_cnt == PANEL_WIDTH) else begin
                    protocol_errors++;
                    $display("latch came after %0d pixel clocks instead of a full row", pix_cnt);
                end
                assert (latch_cnt == 0 || oe_cnt == (BASE_ON_TICKS << disp_plane)) else begin
                    value_errors++;
                    $display("FAIL output_enable cycles before latch %0d: got 0x%h expected 0x%h",
                             latch_cnt, oe_cnt, BASE_ON_TICKS << disp_plane);
                end
                disp_row   = shift_row;
                disp_plane = shift_plane;
                latch_cnt++;
                pix_cnt = 0;
                oe_cnt  = 0;
            end
            oe_q    = panel.output_enable;
            latch_q = panel.latch;
        end
    end

    assert property (@(posedge clk_root) disable iff (reset)
        !(panel.output_enable && (panel.clk_pixel || panel.latch)))
    else begin
        protocol_errors++;
        $display("output_enable was high together with clk_pixel or latch");
    end

    assert property (@(posedge clk_root) disable iff (reset)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
        protocol_errors++;
        $display("pready came outside an APB access phase");
    end

    initial begin : main_sequence
        int addr;
        seed         = 32'h7e1f_15fe;
        reset        = 1'b1;
        apb_req      = '0;
        ctrl_shadow  = 7'h7f;
        regs_changed = 1'b0;
        fb_loaded    = 1'b0;
        stall_cycles = 0;
        repeat (8) @(negedge clk_root);
        assert (!panel.clk_pixel && !panel.latch && !panel.output_enable
                && panel.row_addr == 4'h0 && !apb_rsp.pready && !apb_rsp.pslverr) else begin
            value_errors++;
            $display("FAIL panel/apb_rsp in reset: got 0x%h/0x%h expected 0x0/0x0",
                     {panel.clk_pixel, panel.latch, panel.output_enable, panel.row_addr},
                     {apb_rsp.pready, apb_rsp.pslverr});
        end
        reset = 1'b0;

        for (int a = 0; a < FB_DEPTH; a++) begin
            write_pixel(a, $random(seed));
        end
        fb_loaded = 1'b1;
        repeat (32) begin
            addr = $random(seed) & 32'h7f;
            check_pixel(addr);
        end

        write_ctrl(32'h0000_0125);   // upper bits fall away
        check_ctrl();
        check_decode_error(1'b1);
        check_decode_error(1'b0);
        check_ctrl();                // unmapped write left ctrl alone
        write_ctrl(32'h0000_007f);
        check_ctrl();
        bus_idle();
        wait_latches(18);

        write_ctrl(32'h0000_0047);   // red only, plane 3 off
        check_ctrl();
        bus_idle();
        wait_latches(18);

        // writes against the running scan
        repeat (8) begin
            addr = $random(seed) & 32'h7f;
            write_pixel(addr, $random(seed));
            check_pixel(addr);
        end
        bus_idle();
        wait_latches(6);

        assert (stall_cycles > 0) else begin
            protocol_errors++;
            $display("no pixel write ever waited for the fetch unit");
        end

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
design/hub75_pkg.sv
design/framebuffer_ram.sv
design/fb_arbiter.sv
design/apb_regs.sv
design/scan_sequencer.sv
design/column_fetch.sv
design/hub75_top.sv
tests/hub75_tb.sv

/* Bender.yml */
package:
  name: hub75_driver

sources:
  - files:
      - design/hub75_pkg.sv
      - design/framebuffer_ram.sv
      - design/fb_arbiter.sv
      - design/apb_regs.sv
      - design/scan_sequencer.sv
      - design/column_fetch.sv
      - design/hub75_top.sv
  - target: test
    files:
      - tests/hub75_tb.sv
